//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_sel_t;
    typedef logic [3:0]  stage_vec_t;

    // bit positions in stage_vec_t
    localparam int st_fetch   = 0;
    localparam int st_decode  = 1;
    localparam int st_execute = 2;
    localparam int st_memory  = 3;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_slt, alu_sll, alu_srl, alu_lui
    } alu_op_t;

    // mem_none must stay zero, bubbles rely on it
    typedef enum logic [2:0] {
        mem_none, mem_lw, mem_lb, mem_sw, mem_sb
    } mem_op_t;

    ////////////////////////////////////////////////////////////
    // opcode and function fields
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lb      = 6'h20;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sb      = 6'h28;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_slt     = 6'h2a;

    ////////////////////////////////////////////////////////////
    // stage payloads
    typedef struct packed {
        word_t     pc;
        word_t     a;
        word_t     b;
        word_t     store_data;
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        reg_addr_t dest;
        logic      w_en;
    } id_ex_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        word_t     store_data;
        mem_op_t   mem_op;
        reg_addr_t dest;
        logic      w_en;
    } ex_mem_t;

    typedef struct packed {
        word_t     pc;
        word_t     result;
        reg_addr_t dest;
        logic      w_en;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- source/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire           clk,
    input  wire           arst_n,
    input  wire           stall,
    input  wire           bubble,
    input  wire payload_t d,
    output payload_t      q
);

    // an all-zero payload writes nothing and touches no memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            q <= '0;
        else if (bubble)
            q <= '0;
        else if (!stall)
            q <= d;
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(stall && bubble))
        else $error("pipeline register held and bubbled in one cycle");

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire            clk,
    input  wire            arst_n,
    input  wire reg_addr_t r_addr_1,
    input  wire reg_addr_t r_addr_2,
    input  wire reg_addr_t w_addr,
    input  wire word_t     w_data,
    input  wire            w_en,
    output word_t          r_data_1,
    output word_t          r_data_2
);

    word_t regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (w_en && w_addr != '0) begin
            regs[w_addr] <= w_data;
        end
    end

    // write-first bypass, r0 hardwired to zero
    assign r_data_1 = (r_addr_1 == '0) ? '0 :
                      (w_en && w_addr == r_addr_1) ? w_data : regs[r_addr_1];
    assign r_data_2 = (r_addr_2 == '0) ? '0 :
                      (w_en && w_addr == r_addr_2) ? w_data : regs[r_addr_2];

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`default_nettype none

module fetch_unit import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'hbfc0_0000
) (
    input  wire             clk,
    input  wire             arst_n,
    input  wire word_t      inst,
    input  wire             fetch_available,
    input  wire             branch_taken,
    input  wire word_t      branch_target,
    input  wire stage_vec_t stall,
    input  wire stage_vec_t bubble,
    output word_t           pc,
    output logic            fetch_en,
    output word_t           dec_pc,
    output word_t           dec_inst,
    output logic            dec_valid
);

    logic  run;
    logic  take;
    logic  redirect_now;
    logic  redirect_pending;
    word_t pending_target;

    assign fetch_en     = run && !stall[st_decode];
    assign take         = fetch_en && fetch_available;
    // branch in decode only counts once decode moves on
    assign redirect_now = branch_taken && !stall[st_decode];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run              <= 1'b0;
            pc               <= reset_pc;
            redirect_pending <= 1'b0;
        end else begin
            run <= 1'b1;
            if (take) begin
                // the word taken now is the delay slot when a redirect is due
                if (redirect_now)
                    pc <= branch_target;
                else if (redirect_pending)
                    pc <= pending_target;
                else
                    pc <= pc + 32'd4;
                redirect_pending <= 1'b0;
            end else if (redirect_now) begin
                redirect_pending <= 1'b1;
            end
        end
    end

    // held until the delay slot arrives
    always_ff @(posedge clk) begin
        if (redirect_now)
            pending_target <= branch_target;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            dec_valid <= 1'b0;
        else if (!stall[st_decode])
            dec_valid <= take && !bubble[st_decode];
    end

    always_ff @(posedge clk) begin
        if (!stall[st_decode]) begin
            dec_pc   <= pc;
            dec_inst <= inst;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", pc);

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`default_nettype none

module decode_unit import cpu_pkg::*; (
    input  wire word_t   dec_pc,
    input  wire word_t   dec_inst,
    input  wire          dec_valid,
    output reg_addr_t    r_addr_1,
    output reg_addr_t    r_addr_2,
    input  wire word_t   r_data_1,
    input  wire word_t   r_data_2,
    input  wire ex_mem_t ex_fwd,
    input  wire mem_wb_t mem_fwd,
    input  wire mem_wb_t wb_fwd,
    input  wire          ex_is_load,
    output id_ex_t       id_ex,
    output logic         branch_taken,
    output word_t        branch_target,
    output logic         load_use_req
);

    logic [5:0] op;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      pc_plus4;
    word_t      rs_val;
    word_t      rt_val;
    logic       uses_rs;
    logic       uses_rt;
    logic       writes;
    logic       branch_cond;

    assign op       = dec_inst[31:26];
    assign funct    = dec_inst[5:0];
    assign rs       = dec_inst[25:21];
    assign rt       = dec_inst[20:16];
    assign imm_sext = {{16{dec_inst[15]}}, dec_inst[15:0]};
    assign imm_zext = {16'h0000, dec_inst[15:0]};
    assign pc_plus4 = dec_pc + 32'd4;
    assign r_addr_1 = rs;
    assign r_addr_2 = rt;

    // youngest producer first; w_en is never set for r0
    function automatic word_t forward(reg_addr_t r, word_t rf_val);
        if (ex_fwd.w_en && ex_fwd.dest == r)
            return ex_fwd.result;
        if (mem_fwd.w_en && mem_fwd.dest == r)
            return mem_fwd.result;
        if (wb_fwd.w_en && wb_fwd.dest == r)
            return wb_fwd.result;
        return rf_val;
    endfunction

    always_comb begin
        rs_val = forward(rs, r_data_1);
        rt_val = forward(rt, r_data_2);
    end

    always_comb begin
        id_ex            = '0;
        id_ex.pc         = dec_pc;
        id_ex.a          = rs_val;
        id_ex.b          = rt_val;
        id_ex.store_data = rt_val;
        id_ex.dest       = dec_inst[15:11];
        uses_rs          = 1'b1;
        uses_rt          = 1'b0;
        writes           = 1'b0;
        branch_cond      = 1'b0;
        branch_target    = pc_plus4 + {imm_sext[29:0], 2'b00};
        case (op)
            op_special: begin
                uses_rt = 1'b1;
                writes  = 1'b1;
                case (funct)
                    fn_addu: id_ex.alu_op = alu_add;
                    fn_subu: id_ex.alu_op = alu_sub;
                    fn_and:  id_ex.alu_op = alu_and;
                    fn_or:   id_ex.alu_op = alu_or;
                    fn_xor:  id_ex.alu_op = alu_xor;
                    fn_slt:  id_ex.alu_op = alu_slt;
                    fn_sll, fn_srl: begin
                        // shift amount rides in operand a
                        id_ex.alu_op = (funct == fn_sll) ? alu_sll : alu_srl;
                        id_ex.a      = {27'd0, dec_inst[10:6]};
                        uses_rs      = 1'b0;
                    end
                    default: writes = 1'b0;
                endcase
            end
            op_addiu: begin
                id_ex.b    = imm_sext;
                id_ex.dest = rt;
                writes     = 1'b1;
            end
            op_andi, op_ori: begin
                id_ex.alu_op = (op == op_andi) ? alu_and : alu_or;
                id_ex.b      = imm_zext;
                id_ex.dest   = rt;
                writes       = 1'b1;
            end
            op_lui: begin
                id_ex.alu_op = alu_lui;
                id_ex.b      = imm_zext;
                id_ex.dest   = rt;
                writes       = 1'b1;
                uses_rs      = 1'b0;
            end
            op_lw, op_lb: begin
                id_ex.mem_op = (op == op_lw) ? mem_lw : mem_lb;
                id_ex.b      = imm_sext;
                id_ex.dest   = rt;
                writes       = 1'b1;
            end
            op_sw, op_sb: begin
                id_ex.mem_op = (op == op_sw) ? mem_sw : mem_sb;
                id_ex.b      = imm_sext;
                uses_rt      = 1'b1;
            end
            op_beq, op_bne: begin
                uses_rt     = 1'b1;
                branch_cond = (rs_val == rt_val) == (op == op_beq);
            end
            op_j: begin
                uses_rs       = 1'b0;
                branch_cond   = 1'b1;
                branch_target = {pc_plus4[31:28], dec_inst[25:0], 2'b00};
            end
            default: uses_rs = 1'b0;
        endcase
        id_ex.w_en = dec_valid && writes && id_ex.dest != '0;
        if (!dec_valid)
            id_ex.mem_op = mem_none;
        branch_taken = dec_valid && branch_cond;
        // loaded value only exists one stage later
        load_use_req = dec_valid && ex_is_load && ex_fwd.w_en &&
                       ((uses_rs && ex_fwd.dest == rs) || (uses_rt && ex_fwd.dest == rt));
    end

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`default_nettype none

module execute_unit import cpu_pkg::*; (
    input  wire id_ex_t id_ex,
    output ex_mem_t     ex_mem,
    output logic        ex_is_load
);

    word_t result;

    // loads and stores use alu_add on base and offset
    always_comb begin
        case (id_ex.alu_op)
            alu_add: result = id_ex.a + id_ex.b;
            alu_sub: result = id_ex.a - id_ex.b;
            alu_and: result = id_ex.a & id_ex.b;
            alu_or:  result = id_ex.a | id_ex.b;
            alu_xor: result = id_ex.a ^ id_ex.b;
            alu_slt: result = {31'd0, $signed(id_ex.a) < $signed(id_ex.b)};
            alu_sll: result = id_ex.b << id_ex.a[4:0];
            alu_srl: result = id_ex.b >> id_ex.a[4:0];
            alu_lui: result = {id_ex.b[15:0], 16'h0000};
            default: result = id_ex.a + id_ex.b;
        endcase
    end

    always_comb begin
        ex_mem.pc         = id_ex.pc;
        ex_mem.result     = result;
        ex_mem.store_data = id_ex.store_data;
        ex_mem.mem_op     = id_ex.mem_op;
        ex_mem.dest       = id_ex.dest;
        ex_mem.w_en       = id_ex.w_en;
    end

    assign ex_is_load = id_ex.mem_op inside {mem_lw, mem_lb};

endmodule

`default_nettype wire

//--- source/mem_access.sv
`default_nettype none

module mem_access import cpu_pkg::*; (
    input  wire ex_mem_t ex_mem,
    input  wire word_t   mem_r_data,
    input  wire          mem_available,
    output logic         mem_r_en,
    output logic         mem_w_en,
    output word_t        mem_addr,
    output word_t        mem_w_data,
    output byte_sel_t    mem_sel,
    output mem_wb_t      mem_wb,
    output logic         mem_req
);

    logic       is_byte;
    logic [1:0] lane;
    logic [7:0] load_byte;

    assign lane     = ex_mem.result[1:0];
    assign is_byte  = ex_mem.mem_op inside {mem_lb, mem_sb};
    assign mem_r_en = ex_mem.mem_op inside {mem_lw, mem_lb};
    assign mem_w_en = ex_mem.mem_op inside {mem_sw, mem_sb};
    assign mem_addr = ex_mem.result;
    assign mem_sel  = is_byte ? byte_sel_t'(4'b0001 << lane) : 4'b1111;

    // byte stores put the byte on every lane, mem_sel picks one
    assign mem_w_data = is_byte ? {4{ex_mem.store_data[7:0]}} : ex_mem.store_data;

    // request held by the stall until memory answers
    assign mem_req   = (mem_r_en || mem_w_en) && !mem_available;
    assign load_byte = mem_r_data[8*lane +: 8];

    always_comb begin
        mem_wb.pc   = ex_mem.pc;
        mem_wb.dest = ex_mem.dest;
        mem_wb.w_en = ex_mem.w_en;
        case (ex_mem.mem_op)
            mem_lw:  mem_wb.result = mem_r_data;
            mem_lb:  mem_wb.result = {{24{load_byte[7]}}, load_byte};
            default: mem_wb.result = ex_mem.result;
        endcase
    end

    assert final (!(ex_mem.mem_op inside {mem_lw, mem_sw}) || lane == 2'b00)
        else $error("word access at %h not aligned", ex_mem.result);

endmodule

`default_nettype wire

//--- source/hazard_ctrl.sv
`default_nettype none

module hazard_ctrl import cpu_pkg::*; (
    input  wire        fetch_req,
    input  wire        load_use_req,
    input  wire        mem_req,
    output stage_vec_t stall,
    output stage_vec_t bubble
);

    stage_vec_t req;

    always_comb begin
        req              = '0;
        req[st_fetch]    = fetch_req;
        req[st_decode]   = load_use_req;
        req[st_memory]   = mem_req;
        // a request holds its own stage and all before it
        for (int i = 0; i < 4; i++)
            stall[i] = |(req >> i);
        // first moving stage behind a held one gets a bubble
        bubble = '0;
        for (int i = 1; i < 4; i++)
            bubble[i] = stall[i-1] && !stall[i];
    end

endmodule

`default_nettype wire

//--- source/cpu.sv
`default_nettype none

module cpu import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'hbfc0_0000
) (
    input  wire        clk,
    input  wire        arst_n,
    input  wire word_t inst,
    input  wire        fetch_available,
    output word_t      pc,
    output logic       fetch_en,
    input  wire word_t mem_r_data,
    input  wire        mem_available,
    output logic       mem_r_en,
    output logic       mem_w_en,
    output word_t      mem_addr,
    output word_t      mem_w_data,
    output byte_sel_t  mem_sel,
    output word_t      pc_wb,
    output reg_addr_t  w_addr_wb,
    output word_t      w_data_wb,
    output logic       w_en_wb
);

    stage_vec_t stall;
    stage_vec_t bubble;
    logic       load_use_req;
    logic       mem_req;
    logic       branch_taken;
    word_t      branch_target;
    word_t      dec_pc;
    word_t      dec_inst;
    logic       dec_valid;
    reg_addr_t  r_addr_1;
    reg_addr_t  r_addr_2;
    word_t      r_data_1;
    word_t      r_data_2;
    logic       ex_is_load;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;
    ex_mem_t    ex_mem_d;
    ex_mem_t    ex_mem_q;
    mem_wb_t    mem_wb_d;
    mem_wb_t    mem_wb_q;

    // trace mirrors the register file write
    assign pc_wb     = mem_wb_q.pc;
    assign w_addr_wb = mem_wb_q.dest;
    assign w_data_wb = mem_wb_q.result;
    assign w_en_wb   = mem_wb_q.w_en;

    ////////////////////////////////////////////////////////////
    // fetch and decode
    fetch_unit #(.reset_pc(reset_pc)) fetch_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .inst            (inst),
        .fetch_available (fetch_available),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .stall           (stall),
        .bubble          (bubble),
        .pc              (pc),
        .fetch_en        (fetch_en),
        .dec_pc          (dec_pc),
        .dec_inst        (dec_inst),
        .dec_valid       (dec_valid)
    );

    decode_unit decode_i (
        .dec_pc        (dec_pc),
        .dec_inst      (dec_inst),
        .dec_valid     (dec_valid),
        .r_addr_1      (r_addr_1),
        .r_addr_2      (r_addr_2),
        .r_data_1      (r_data_1),
        .r_data_2      (r_data_2),
        .ex_fwd        (ex_mem_d),
        .mem_fwd       (mem_wb_d),
        .wb_fwd        (mem_wb_q),
        .ex_is_load    (ex_is_load),
        .id_ex         (id_ex_d),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .load_use_req  (load_use_req)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .r_addr_1 (r_addr_1),
        .r_addr_2 (r_addr_2),
        .w_addr   (mem_wb_q.dest),
        .w_data   (mem_wb_q.result),
        .w_en     (mem_wb_q.w_en),
        .r_data_1 (r_data_1),
        .r_data_2 (r_data_2)
    );

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg_i (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall[st_execute]),
        .bubble (bubble[st_execute]),
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    ////////////////////////////////////////////////////////////
    // execute, memory, write-back
    execute_unit execute_i (
        .id_ex      (id_ex_q),
        .ex_mem     (ex_mem_d),
        .ex_is_load (ex_is_load)
    );

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg_i (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall[st_memory]),
        .bubble (bubble[st_memory]),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    mem_access mem_access_i (
        .ex_mem        (ex_mem_q),
        .mem_r_data    (mem_r_data),
        .mem_available (mem_available),
        .mem_r_en      (mem_r_en),
        .mem_w_en      (mem_w_en),
        .mem_addr      (mem_addr),
        .mem_w_data    (mem_w_data),
        .mem_sel       (mem_sel),
        .mem_wb        (mem_wb_d),
        .mem_req       (mem_req)
    );

    // write-back never stalls, it takes a bubble while memory waits
    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg_i (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (1'b0),
        .bubble (stall[st_memory]),
        .d      (mem_wb_d),
        .q      (mem_wb_q)
    );

    hazard_ctrl hazard_i (
        .fetch_req    (fetch_en && !fetch_available),
        .load_use_req (load_use_req),
        .mem_req      (mem_req),
        .stall        (stall),
        .bubble       (bubble)
    );

endmodule

`default_nettype wire

//--- sim/tb_mem_model.sv
`default_nettype none

module tb_mem_model import cpu_pkg::*; #(
    parameter word_t reset_pc = 32'hbfc0_0000
) (
    input  wire        clk,
    input  wire        chaos,
    input  wire word_t pc,
    output word_t      inst,
    output logic       fetch_available,
    input  wire        mem_r_en,
    input  wire        mem_w_en,
    input  wire word_t mem_addr,
    input  wire word_t mem_w_data,
    input  wire byte_sel_t mem_sel,
    output word_t      mem_r_data,
    output logic       mem_available
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t       imem [256];
    word_t       dmem [256];
    word_t       inst_off;
    logic [31:0] rnd_state;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // unused code words are nops and data words carry their own address
    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = 32'h5a00_0000 ^ word_t'(i << 2);
        end
    endtask

    task automatic write_inst(input word_t addr, input word_t word);
        word_t off;
        off = addr - reset_pc;
        imem[off[9:2]] = word;
    endtask

    task automatic write_data(input word_t addr, input word_t word);
        dmem[addr[9:2]] = word;
    endtask

    initial begin
        rnd_state       = 32'h2a0f;
        fetch_available = 1'b1;
        mem_available   = 1'b1;
        clear_memories();
    end

    assign inst_off   = pc - reset_pc;
    assign inst       = (inst_off < 32'd1024) ? imem[inst_off[9:2]] : '0;
    assign mem_r_data = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        rnd_state = xorshift(rnd_state);
        fetch_available <= !chaos || rnd_state[1:0] != 2'b00;
        mem_available   <= !chaos || rnd_state[5:4] != 2'b00;
        if (mem_w_en && mem_available) begin
            for (int b = 0; b < 4; b++)
                if (mem_sel[b])
                    dmem[mem_addr[9:2]][8*b +: 8] <= mem_w_data[8*b +: 8];
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_cpu.sv
`default_nettype none

module tb_cpu import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam word_t boot_pc = 32'hbfc0_0000;

    logic      clk = 1'b0;
    logic      arst_n = 1'b0;
    logic      chaos = 1'b0;
    word_t     inst, pc, mem_r_data, mem_addr, mem_w_data, pc_wb, w_data_wb;
    logic      fetch_available, fetch_en, mem_available, mem_r_en, mem_w_en, w_en_wb;
    byte_sel_t mem_sel;
    reg_addr_t w_addr_wb;

    // test table with one entry per file line
    string test_name[$];
    bit    test_chaos[$];
    int    inst_test[$], data_test[$], rec_test[$], rec_kind[$];
    word_t inst_addr[$], inst_word[$], data_addr[$], data_word[$];
    word_t rec_a[$], rec_b[$], rec_c[$];

    // records still due in the running test (kind 1 is a write and kind 2 a store)
    int    exp_kind[$];
    word_t exp_a[$], exp_b[$], exp_c[$];
    string cur_name;
    int    test_errors;
    int    pass_count = 0;
    int    fail_count = 0;

    always #50 clk = ~clk;

    cpu #(.reset_pc(boot_pc)) dut_i (
        .clk(clk), .arst_n(arst_n), .inst(inst), .fetch_available(fetch_available),
        .pc(pc), .fetch_en(fetch_en), .mem_r_data(mem_r_data),
        .mem_available(mem_available), .mem_r_en(mem_r_en), .mem_w_en(mem_w_en),
        .mem_addr(mem_addr), .mem_w_data(mem_w_data), .mem_sel(mem_sel),
        .pc_wb(pc_wb), .w_addr_wb(w_addr_wb), .w_data_wb(w_data_wb), .w_en_wb(w_en_wb)
    );

    tb_mem_model #(.reset_pc(boot_pc)) mem_i (
        .clk(clk), .chaos(chaos), .pc(pc), .inst(inst),
        .fetch_available(fetch_available), .mem_r_en(mem_r_en), .mem_w_en(mem_w_en),
        .mem_addr(mem_addr), .mem_w_data(mem_w_data), .mem_sel(mem_sel),
        .mem_r_data(mem_r_data), .mem_available(mem_available)
    );

    task automatic read_tests(output int ok);
        int    fd;
        int    n;
        int    want;
        int    flag;
        string line, tag, name;
        word_t a, b, c;
        ok = 0;
        fd = $fopen("sim/cpu_tests.txt", "r");
        if (fd == 0)
            return;
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 2 || line[0] == "#")
                continue;
            n    = $sscanf(line, "%s", tag);
            want = 0;
            if (tag == "T") begin
                n    = $sscanf(line, "%s %s %d", tag, name, flag);
                want = 3;
                test_name.push_back(name);
                test_chaos.push_back(flag != 0);
            end else if (tag == "I" || tag == "D") begin
                n    = $sscanf(line, "%s %h %h", tag, a, b);
                want = 3;
                if (tag == "I") begin
                    inst_test.push_back(test_name.size() - 1);
                    inst_addr.push_back(a);
                    inst_word.push_back(b);
                end else begin
                    data_test.push_back(test_name.size() - 1);
                    data_addr.push_back(a);
                    data_word.push_back(b);
                end
            end else if (tag == "W" || tag == "S") begin
                n    = $sscanf(line, "%s %h %h %h", tag, a, b, c);
                want = 4;
                rec_test.push_back(test_name.size() - 1);
                rec_kind.push_back(tag == "W" ? 1 : 2);
                rec_a.push_back(a);
                rec_b.push_back(b);
                rec_c.push_back(c);
            end
            if (n != want) begin
                $display("bad line in sim/cpu_tests.txt starting with %s", tag);
                $fclose(fd);
                return;
            end
        end
        $fclose(fd);
        ok = 1;
    endtask

    task automatic drop_expected();
        void'(exp_kind.pop_front());
        void'(exp_a.pop_front());
        void'(exp_b.pop_front());
        void'(exp_c.pop_front());
    endtask

    task automatic check_wb(input word_t pc_v, input reg_addr_t addr_v, input word_t data_v);
        if (exp_kind.size() == 0) begin
            $display("test %s: unexpected extra write to r%0d", cur_name, addr_v);
            test_errors++;
            return;
        end
        if (exp_kind[0] != 1) begin
            $display("test %s: register write to r%0d came where a store was due",
                     cur_name, addr_v);
            test_errors++;
        end else if (pc_v !== exp_a[0] || addr_v !== reg_addr_t'(exp_b[0])
                     || data_v !== exp_c[0]) begin
            $display("error %s: write expected pc %h r%0d %h, actual pc %h r%0d %h",
                     cur_name, exp_a[0], exp_b[0], exp_c[0], pc_v, addr_v, data_v);
            test_errors++;
        end
        drop_expected();
    endtask

    task automatic check_store(input word_t addr_v, input byte_sel_t sel_v, input word_t data_v);
        if (exp_kind.size() == 0) begin
            $display("test %s: unexpected extra store to %h", cur_name, addr_v);
            test_errors++;
            return;
        end
        if (exp_kind[0] != 2) begin
            $display("test %s: store to %h came where a register write was due",
                     cur_name, addr_v);
            test_errors++;
        end else if (addr_v !== exp_a[0] || sel_v !== byte_sel_t'(exp_b[0])
                     || data_v !== exp_c[0]) begin
            $display("error %s: store expected %h sel %b %h, actual %h sel %b %h",
                     cur_name, exp_a[0], byte_sel_t'(exp_b[0]), exp_c[0],
                     addr_v, sel_v, data_v);
            test_errors++;
        end
        drop_expected();
    endtask

    task automatic check_reset_outputs(input string when);
        if (pc !== boot_pc) begin
            $display("error %s: pc %s expected %h, actual %h", cur_name, when, boot_pc, pc);
            test_errors++;
        end
        if (w_en_wb !== 1'b0 || mem_r_en !== 1'b0 || mem_w_en !== 1'b0
            || fetch_en !== 1'b0) begin
            $display("test %s: an enable is not low %s", cur_name, when);
            test_errors++;
        end
    endtask

    // write-back goes first as it belongs to the older instruction
    task automatic observe_cycle();
        @(negedge clk);
        if (w_en_wb)
            check_wb(pc_wb, w_addr_wb, w_data_wb);
        if (mem_w_en && mem_available)
            check_store(mem_addr, mem_sel, mem_w_data);
    endtask

    task automatic run_test(input int t);
        cur_name    = test_name[t];
        test_errors = 0;
        exp_kind.delete();
        exp_a.delete();
        exp_b.delete();
        exp_c.delete();
        foreach (rec_test[i]) begin
            if (rec_test[i] == t) begin
                exp_kind.push_back(rec_kind[i]);
                exp_a.push_back(rec_a[i]);
                exp_b.push_back(rec_b[i]);
                exp_c.push_back(rec_c[i]);
            end
        end
        @(posedge clk);
        arst_n <= 1'b0;
        chaos  <= test_chaos[t];
        for (int c = 0; c < 5; c++) begin
            @(negedge clk);
            if (c == 0) begin
                mem_i.clear_memories();
                foreach (inst_test[i])
                    if (inst_test[i] == t)
                        mem_i.write_inst(inst_addr[i], inst_word[i]);
                foreach (data_test[i])
                    if (data_test[i] == t)
                        mem_i.write_data(data_addr[i], data_word[i]);
            end
            check_reset_outputs("during reset");
        end
        @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_reset_outputs("right after reset");
        while (exp_kind.size() > 0)
            observe_cycle();
        // a few more cycles to catch anything extra
        repeat (12)
            observe_cycle();
        if (test_errors == 0) begin
            $display("test %s: ok", cur_name);
            pass_count++;
        end else begin
            $display("test %s: %0d problems", cur_name, test_errors);
            fail_count++;
        end
    endtask

    initial begin
        int ok;
        int limit;
        read_tests(ok);
        if (ok == 0) begin
            $display("cannot read sim/cpu_tests.txt");
            $display("TB FAILED");
            $finish;
        end else begin
            limit = rec_test.size() * 40 + 100;
            fork
                begin
                    repeat (limit) @(posedge clk);
                    $display("watchdog: run still busy after %0d cycles", limit);
                    $display("TB FAILED");
                    $finish;
                end
            join_none
            foreach (test_name[t])
                run_test(t);
            $display("%0d tests run, %0d passed, %0d failed",
                     test_name.size(), pass_count, fail_count);
            if (fail_count == 0 && test_name.size() > 0)
                $display("TB PASSED");
            else
                $display("TB FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- compile.f
source/cpu_pkg.sv
source/pipe_reg.sv
source/reg_file.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execute_unit.sv
source/mem_access.sv
source/hazard_ctrl.sv
source/cpu.sv
sim/tb_mem_model.sv
sim/tb_cpu.sv

//--- sim/cpu_tests.txt
# T name chaos | I pc word | D addr word | W pc reg value | S addr sel data
# all numbers hex except the chaos flag, records listed in completion order
T alu 0
I bfc00000 3c011234
I bfc00004 34215678
I bfc00008 2402fffd
I bfc0000c 00221821
I bfc00010 00412023
I bfc00014 0041282a
I bfc00018 00223024
I bfc0001c 00223826
I bfc00020 00014100
I bfc00024 00024f02
I bfc00028 24200005
I bfc0002c 302aff00
I bfc00030 01405825
W bfc00000 01 12340000
W bfc00004 01 12345678
W bfc00008 02 fffffffd
W bfc0000c 03 12345675
W bfc00010 04 edcba985
W bfc00014 05 00000001
W bfc00018 06 12345678
W bfc0001c 07 edcba985
W bfc00020 08 23456780
W bfc00024 09 0000000f
W bfc0002c 0a 00005600
W bfc00030 0b 00005600
T mem 1
D 00000010 11223344
D 00000014 0000a5f0
I bfc00000 24010010
I bfc00004 8c220000
I bfc00008 00421821
I bfc0000c 80240005
I bfc00010 ac230008
I bfc00014 a024000b
I bfc00018 8c250008
I bfc0001c 80260000
I bfc00020 00c53821
W bfc00000 01 00000010
W bfc00004 02 11223344
W bfc00008 03 22446688
W bfc0000c 04 ffffffa5
S 00000018 f 22446688
S 0000001b 8 a5a5a5a5
W bfc00018 05 a5446688
W bfc0001c 06 00000044
W bfc00020 07 a54466cc
T branch 1
I bfc00000 24010001
I bfc00004 10200002
I bfc00008 24020002
I bfc0000c 14200003
I bfc00010 24030003
I bfc00014 24040004
I bfc00018 24040005
I bfc0001c 10000003
I bfc00020 24050006
I bfc00024 24060007
I bfc00028 24060008
I bfc0002c 0bf0000f
I bfc00030 24070009
I bfc00034 2408000a
I bfc00038 2408000b
I bfc0003c 2409000c
I bfc00040 11210005
I bfc00044 240a000d
I bfc00048 240b000e
W bfc00000 01 00000001
W bfc00008 02 00000002
W bfc00010 03 00000003
W bfc00020 05 00000006
W bfc00030 07 00000009
W bfc0003c 09 0000000c
W bfc00044 0a 0000000d
W bfc00048 0b 0000000e
